// ==== hdl/icache_pkg.sv ====
// Shared definitions for the private instruction cache
// Geometry constants, vector types, bus structs and controller states

package icache_pkg;

   ///////////////////////////////
   // Geometry
   ///////////////////////////////
   localparam int ADDR_W    = 32;     // Fetch address
   localparam int LINE_W    = 128;    // One line is one fetch beat
   localparam int NB_WAYS   = 4;
   localparam int NB_SETS   = 16;
   localparam int OFFSET_W  = 4;      // Byte offset inside a line
   localparam int SET_W     = 4;
   localparam int TAG_W     = 7;      // Address bits [14:8]
   localparam int STAT_W    = 32;
   localparam logic [7:0] LFSR_SEED = 8'hA5;

   typedef logic [ADDR_W-1:0]  addr_t;
   typedef logic [LINE_W-1:0]  line_t;
   typedef logic [SET_W-1:0]   set_idx_t;
   typedef logic [TAG_W-1:0]   tag_t;
   typedef logic [NB_WAYS-1:0] way_oh_t;
   typedef logic [STAT_W-1:0]  stat_cnt_t;

   ///////////////////////////////
   // Structs
   ///////////////////////////////
   typedef struct packed {
      logic valid;
      tag_t tag;
   } tag_entry_t;

   typedef struct packed {
      way_oh_t    way_mask;   // Ways written this cycle
      set_idx_t   set_idx;
      tag_entry_t entry;
   } tag_wr_t;

   typedef struct packed {
      logic  req;
      addr_t addr;
   } refill_req_t;

   typedef struct packed {
      logic  gnt;
      logic  valid;
      line_t data;
   } refill_rsp_t;

   typedef struct packed {
      logic  valid;
      line_t data;
   } fetch_rsp_t;

   // One-cycle strobes for the statistics block
   typedef struct packed {
      logic trans;
      logic hit;
      logic miss;
      logic evict;
   } perf_event_t;

   typedef enum logic [3:0] {
      DISABLED,
      BYPASS_REFILL,
      BYPASS_WAIT,
      FLUSH_ALL,
      FLUSH_SET,
      IDLE,
      TAG_LOOKUP,
      WAIT_REFILL_GNT,
      WAIT_REFILL_DONE
   } ctrl_state_t;

endpackage

// ==== hdl/icache_tag_store.sv ====
// Valid and tag storage for every way and set
// Registered read with per-way hit and valid compare

`timescale 1ns/1ps

module icache_tag_store
(
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   rd_en_i,
   input  icache_pkg::set_idx_t   rd_set_i,
   input  icache_pkg::tag_t       cmp_tag_i,     // From the registered fetch address
   input  icache_pkg::tag_wr_t    wr_i,
   output icache_pkg::way_oh_t    hit_ways_o,
   output icache_pkg::way_oh_t    valid_ways_o
);

   icache_pkg::tag_entry_t tags_q [icache_pkg::NB_SETS][icache_pkg::NB_WAYS];
   icache_pkg::tag_entry_t rd_q   [icache_pkg::NB_WAYS];

   always_ff @(posedge clk, negedge rst_n)
   begin
      if (!rst_n)
      begin
         for (int s = 0; s < icache_pkg::NB_SETS; s++)
         begin
            for (int w = 0; w < icache_pkg::NB_WAYS; w++)
            begin
               tags_q[s][w] <= '0;   // Everything starts invalid
            end
         end
         for (int w = 0; w < icache_pkg::NB_WAYS; w++)
         begin
            rd_q[w] <= '0;
         end
      end
      else
      begin
         for (int w = 0; w < icache_pkg::NB_WAYS; w++)
         begin
            if (wr_i.way_mask[w])
               tags_q[wr_i.set_idx][w] <= wr_i.entry;
            if (rd_en_i)
               rd_q[w] <= tags_q[rd_set_i][w];
         end
      end
   end

   // Compare runs on the read register, one cycle after the request
   always_comb
   begin
      for (int w = 0; w < icache_pkg::NB_WAYS; w++)
      begin
         valid_ways_o[w] = rd_q[w].valid;
         hit_ways_o[w]   = rd_q[w].valid && (rd_q[w].tag == cmp_tag_i);
      end
   end

   // A line lives in one way only, so refill must never duplicate a tag
   hit_onehot_a: assert property (@(posedge clk) disable iff (!rst_n)
      $onehot0(hit_ways_o));

endmodule

// ==== hdl/icache_data_store.sv ====
// Per-way line storage
// One-hot refill write, registered read of all ways at one set

`timescale 1ns/1ps

module icache_data_store
(
   input  logic                                           clk,
   input  logic                                           rd_en_i,
   input  icache_pkg::set_idx_t                           rd_set_i,
   input  icache_pkg::way_oh_t                            wr_mask_i,
   input  icache_pkg::set_idx_t                           wr_set_i,
   input  icache_pkg::line_t                              wr_line_i,
   output icache_pkg::line_t [icache_pkg::NB_WAYS-1:0]    rd_lines_o
);

   genvar w;

   // One line array per way
   for (w = 0; w < icache_pkg::NB_WAYS; w++)
   begin : g_way
      icache_pkg::line_t lines_q [icache_pkg::NB_SETS];

      always_ff @(posedge clk)
      begin
         if (wr_mask_i[w])
            lines_q[wr_set_i] <= wr_line_i;
         if (rd_en_i)
            rd_lines_o[w] <= lines_q[rd_set_i];   // Read data valid next cycle
      end
   end

endmodule

// ==== hdl/icache_victim_select.sv ====
// Replacement way selection
// 8-bit LFSR for a random way, highest invalid way search, one-hot result

`timescale 1ns/1ps

module icache_victim_select
(
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  advance_i,      // Step after a random pick
   input  icache_pkg::way_oh_t   valid_ways_i,
   output icache_pkg::way_oh_t   victim_o
);

   localparam int WAY_IDX_W = $clog2(icache_pkg::NB_WAYS);

   logic [7:0]            lfsr_q;
   logic                  feedback;
   logic [WAY_IDX_W-1:0]  free_idx;
   icache_pkg::way_oh_t   rand_oh;
   icache_pkg::way_oh_t   free_oh;

   // Taps 8,6,5,4 give the full 255 cycle
   assign feedback = lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3];

   always_ff @(posedge clk, negedge rst_n)
   begin
      if (!rst_n)
         lfsr_q <= icache_pkg::LFSR_SEED;
      else if (advance_i)
         lfsr_q <= {lfsr_q[6:0], feedback};
   end

   assign rand_oh = icache_pkg::way_oh_t'(1) << lfsr_q[WAY_IDX_W-1:0];

   // Last match wins, so the highest-numbered invalid way is taken
   always_comb
   begin
      free_idx = '0;
      for (int w = 0; w < icache_pkg::NB_WAYS; w++)
      begin
         if (!valid_ways_i[w])
            free_idx = w[WAY_IDX_W-1:0];
      end
   end

   assign free_oh  = icache_pkg::way_oh_t'(1) << free_idx;
   assign victim_o = (&valid_ways_i) ? rand_oh : free_oh;

endmodule

// ==== hdl/icache_ctrl_fsm.sv ====
// Main cache controller
// Bypass, flush, lookup and refill sequencing
// Drives the fetch port, the refill port and the tag and data stores

`timescale 1ns/1ps

module icache_ctrl_fsm
(
   input  logic                                           clk,
   input  logic                                           rst_n,
   input  logic                                           fetch_req_i,
   input  icache_pkg::addr_t                              fetch_addr_i,
   input  logic                                           bypass_i,
   input  logic                                           flush_i,
   input  logic                                           flush_set_req_i,
   input  icache_pkg::addr_t                              flush_set_addr_i,
   input  icache_pkg::refill_rsp_t                        refill_rsp_i,
   input  icache_pkg::way_oh_t                            hit_ways_i,
   input  icache_pkg::way_oh_t                            valid_ways_i,
   input  icache_pkg::way_oh_t                            victim_i,
   input  icache_pkg::line_t [icache_pkg::NB_WAYS-1:0]    rd_lines_i,
   output logic                                           fetch_gnt_o,
   output icache_pkg::fetch_rsp_t                         fetch_rsp_o,
   output icache_pkg::refill_req_t                        refill_req_o,
   output logic                                           tag_rd_en_o,
   output icache_pkg::set_idx_t                           rd_set_o,
   output icache_pkg::tag_t                               cmp_tag_o,
   output icache_pkg::tag_wr_t                            tag_wr_o,
   output icache_pkg::way_oh_t                            data_wr_mask_o,
   output icache_pkg::set_idx_t                           data_wr_set_o,
   output icache_pkg::line_t                              data_wr_line_o,
   output logic                                           victim_advance_o,
   output icache_pkg::perf_event_t                        perf_o,
   output logic                                           cache_is_bypassed_o,
   output logic                                           cache_is_flushed_o,
   output logic                                           flush_set_ack_o
);

   localparam int SET_LSB = icache_pkg::OFFSET_W;
   localparam int TAG_LSB = icache_pkg::OFFSET_W + icache_pkg::SET_W;

   icache_pkg::ctrl_state_t  state_q, state_d;
   icache_pkg::addr_t        addr_q;            // Address of the granted fetch
   icache_pkg::way_oh_t      victim_q;
   icache_pkg::set_idx_t     flush_cnt_q, flush_cnt_d;
   icache_pkg::set_idx_t     addr_set;
   icache_pkg::line_t        hit_line;
   logic                     latch_victim;

   always_ff @(posedge clk, negedge rst_n)
   begin
      if (!rst_n)
      begin
         state_q     <= icache_pkg::DISABLED;
         flush_cnt_q <= '0;
         victim_q    <= '0;
      end
      else
      begin
         state_q     <= state_d;
         flush_cnt_q <= flush_cnt_d;
         if (latch_victim)
            victim_q <= victim_i;
      end
   end

   always_ff @(posedge clk)
   begin
      if (fetch_req_i && fetch_gnt_o)
         addr_q <= fetch_addr_i;
   end

   assign addr_set  = addr_q[SET_LSB +: icache_pkg::SET_W];
   assign cmp_tag_o = addr_q[TAG_LSB +: icache_pkg::TAG_W];

   // Hit mask is one-hot, an OR of the masked ways picks the line
   always_comb
   begin
      hit_line = '0;
      for (int w = 0; w < icache_pkg::NB_WAYS; w++)
      begin
         if (hit_ways_i[w])
            hit_line = hit_line | rd_lines_i[w];
      end
   end

   ///////////////////////////////
   // Next state and outputs
   ///////////////////////////////
   always_comb
   begin
      state_d             = state_q;
      flush_cnt_d         = flush_cnt_q;
      latch_victim        = 1'b0;
      fetch_gnt_o         = 1'b0;
      fetch_rsp_o.valid   = 1'b0;
      fetch_rsp_o.data    = refill_rsp_i.data;
      refill_req_o.req    = 1'b0;
      refill_req_o.addr   = {addr_q[icache_pkg::ADDR_W-1:SET_LSB], {SET_LSB{1'b0}}};
      tag_rd_en_o         = 1'b0;
      rd_set_o            = fetch_addr_i[SET_LSB +: icache_pkg::SET_W];
      tag_wr_o.way_mask   = '0;
      tag_wr_o.set_idx    = addr_set;
      tag_wr_o.entry      = {1'b1, cmp_tag_o};
      data_wr_mask_o      = '0;
      data_wr_set_o       = addr_set;
      data_wr_line_o      = refill_rsp_i.data;
      victim_advance_o    = 1'b0;
      perf_o              = '0;
      cache_is_bypassed_o = 1'b0;
      cache_is_flushed_o  = 1'b0;
      flush_set_ack_o     = 1'b0;

      case (state_q)
         icache_pkg::DISABLED:
         begin
            flush_set_ack_o     = 1'b1;
            cache_is_bypassed_o = 1'b1;
            cache_is_flushed_o  = 1'b1;
            flush_cnt_d         = '0;
            if (bypass_i)
            begin
               fetch_gnt_o = fetch_req_i;   // Granted at once, forwarded next cycle
               if (fetch_req_i)
                  state_d = icache_pkg::BYPASS_REFILL;
            end
            else
               state_d = icache_pkg::FLUSH_ALL;
         end

         icache_pkg::BYPASS_REFILL:
         begin
            flush_set_ack_o     = 1'b1;
            cache_is_bypassed_o = 1'b1;
            cache_is_flushed_o  = 1'b1;
            refill_req_o.req    = 1'b1;
            if (refill_rsp_i.gnt)
               state_d = icache_pkg::BYPASS_WAIT;
         end

         icache_pkg::BYPASS_WAIT:
         begin
            flush_set_ack_o     = 1'b1;
            cache_is_bypassed_o = 1'b1;
            cache_is_flushed_o  = 1'b1;
            fetch_rsp_o.valid   = refill_rsp_i.valid;
            if (refill_rsp_i.valid)
               state_d = icache_pkg::DISABLED;
         end

         icache_pkg::FLUSH_ALL:
         begin
            flush_set_ack_o   = 1'b1;
            tag_wr_o.way_mask = '1;
            tag_wr_o.set_idx  = flush_cnt_q;
            tag_wr_o.entry    = '0;
            if (flush_cnt_q == icache_pkg::set_idx_t'(icache_pkg::NB_SETS - 1))
            begin
               cache_is_flushed_o = 1'b1;   // Pulse on the last set
               flush_cnt_d        = '0;
               state_d            = icache_pkg::IDLE;
            end
            else
               flush_cnt_d = flush_cnt_q + 1'b1;
         end

         icache_pkg::FLUSH_SET:
         begin
            flush_set_ack_o   = 1'b1;
            tag_wr_o.way_mask = '1;
            tag_wr_o.set_idx  = flush_set_addr_i[SET_LSB +: icache_pkg::SET_W];
            tag_wr_o.entry    = '0;
            state_d           = icache_pkg::IDLE;
         end

         icache_pkg::IDLE:
         begin
            if (bypass_i)
               state_d = icache_pkg::DISABLED;
            else if (flush_i)
               state_d = icache_pkg::FLUSH_ALL;
            else if (flush_set_req_i)
               state_d = icache_pkg::FLUSH_SET;
            else
            begin
               fetch_gnt_o = fetch_req_i;
               tag_rd_en_o = fetch_req_i;   // Tag and data read together
               if (fetch_req_i)
                  state_d = icache_pkg::TAG_LOOKUP;
            end
         end

         icache_pkg::TAG_LOOKUP:
         begin
            if (|hit_ways_i)
            begin
               perf_o.hit        = 1'b1;
               fetch_rsp_o.valid = 1'b1;
               fetch_rsp_o.data  = hit_line;
               fetch_gnt_o       = fetch_req_i;   // Keep streaming hits
               tag_rd_en_o       = fetch_req_i;
               state_d           = fetch_req_i ? icache_pkg::TAG_LOOKUP : icache_pkg::IDLE;
            end
            else
            begin
               perf_o.miss      = 1'b1;
               perf_o.evict     = &valid_ways_i;
               victim_advance_o = &valid_ways_i;
               latch_victim     = 1'b1;
               refill_req_o.req = 1'b1;
               state_d          = refill_rsp_i.gnt ? icache_pkg::WAIT_REFILL_DONE
                                                   : icache_pkg::WAIT_REFILL_GNT;
            end
         end

         icache_pkg::WAIT_REFILL_GNT:
         begin
            refill_req_o.req = 1'b1;
            if (refill_rsp_i.gnt)
               state_d = icache_pkg::WAIT_REFILL_DONE;
         end

         icache_pkg::WAIT_REFILL_DONE:
         begin
            // Refill beat goes to the core and into the victim way together
            fetch_rsp_o.valid = refill_rsp_i.valid;
            data_wr_mask_o    = victim_q & {icache_pkg::NB_WAYS{refill_rsp_i.valid}};
            tag_wr_o.way_mask = victim_q & {icache_pkg::NB_WAYS{refill_rsp_i.valid}};
            if (refill_rsp_i.valid)
               state_d = icache_pkg::IDLE;
         end

         default:
            state_d = icache_pkg::DISABLED;
      endcase

      perf_o.trans = fetch_req_i && fetch_gnt_o;
   end

   // Request and address hold until the next level grants
   refill_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
      refill_req_o.req && !refill_rsp_i.gnt |=> refill_req_o.req && $stable(refill_req_o.addr));

   // A refill beat lands in exactly one way
   refill_wr_onehot_a: assert property (@(posedge clk) disable iff (!rst_n)
      state_q == icache_pkg::WAIT_REFILL_DONE && refill_rsp_i.valid |-> $onehot(data_wr_mask_o));

endmodule

// ==== hdl/icache_perf_counters.sv ====
// Statistics counters for transactions, hits, misses and evictions
// Clear has priority over counting, counting needs enable

`timescale 1ns/1ps

module icache_perf_counters
(
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic                      clear_i,
   input  logic                      enable_i,
   input  icache_pkg::perf_event_t   event_i,
   output icache_pkg::stat_cnt_t     stat_trans_o,
   output icache_pkg::stat_cnt_t     stat_hit_o,
   output icache_pkg::stat_cnt_t     stat_miss_o,
   output icache_pkg::stat_cnt_t     stat_evict_o
);

   localparam int NB_CNT = $bits(icache_pkg::perf_event_t);

   logic [NB_CNT-1:0]      ev;
   icache_pkg::stat_cnt_t  cnt_q [NB_CNT];

   assign ev = event_i;   // Bit 3 trans, bit 0 evict

   always_ff @(posedge clk, negedge rst_n)
   begin
      if (!rst_n)
      begin
         for (int i = 0; i < NB_CNT; i++)
         begin
            cnt_q[i] <= '0;
         end
      end
      else if (clear_i)
      begin
         for (int i = 0; i < NB_CNT; i++)
         begin
            cnt_q[i] <= '0;
         end
      end
      else if (enable_i)
      begin
         for (int i = 0; i < NB_CNT; i++)
         begin
            if (ev[i])
               cnt_q[i] <= cnt_q[i] + 1'b1;
         end
      end
   end

   assign stat_trans_o = cnt_q[3];
   assign stat_hit_o   = cnt_q[2];
   assign stat_miss_o  = cnt_q[1];
   assign stat_evict_o = cnt_q[0];

endmodule

// ==== hdl/pri_icache.sv ====
// Private instruction cache top level
// Controller, tag store, data store, victim selection and statistics

`timescale 1ns/1ps

module pri_icache
(
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic                      fetch_req_i,
   input  icache_pkg::addr_t         fetch_addr_i,
   output logic                      fetch_gnt_o,
   output icache_pkg::fetch_rsp_t    fetch_rsp_o,
   output icache_pkg::refill_req_t   refill_req_o,
   input  icache_pkg::refill_rsp_t   refill_rsp_i,
   input  logic                      bypass_i,
   input  logic                      flush_i,
   input  logic                      flush_set_req_i,
   input  icache_pkg::addr_t         flush_set_addr_i,
   output logic                      flush_set_ack_o,
   output logic                      cache_is_bypassed_o,
   output logic                      cache_is_flushed_o,
   input  logic                      stat_clear_i,
   input  logic                      stat_enable_i,
   output icache_pkg::stat_cnt_t     stat_trans_o,
   output icache_pkg::stat_cnt_t     stat_hit_o,
   output icache_pkg::stat_cnt_t     stat_miss_o,
   output icache_pkg::stat_cnt_t     stat_evict_o
);

   logic                                          rd_en;
   icache_pkg::set_idx_t                          rd_set;
   icache_pkg::tag_t                              cmp_tag;
   icache_pkg::tag_wr_t                           tag_wr;
   icache_pkg::way_oh_t                           hit_ways;
   icache_pkg::way_oh_t                           valid_ways;
   icache_pkg::way_oh_t                           victim;
   logic                                          victim_advance;
   icache_pkg::way_oh_t                           data_wr_mask;
   icache_pkg::set_idx_t                          data_wr_set;
   icache_pkg::line_t                             data_wr_line;
   icache_pkg::line_t [icache_pkg::NB_WAYS-1:0]   rd_lines;
   icache_pkg::perf_event_t                       perf;

   icache_ctrl_fsm u_ctrl (
      .clk                 (clk),
      .rst_n               (rst_n),
      .fetch_req_i         (fetch_req_i),
      .fetch_addr_i        (fetch_addr_i),
      .bypass_i            (bypass_i),
      .flush_i             (flush_i),
      .flush_set_req_i     (flush_set_req_i),
      .flush_set_addr_i    (flush_set_addr_i),
      .refill_rsp_i        (refill_rsp_i),
      .hit_ways_i          (hit_ways),
      .valid_ways_i        (valid_ways),
      .victim_i            (victim),
      .rd_lines_i          (rd_lines),
      .fetch_gnt_o         (fetch_gnt_o),
      .fetch_rsp_o         (fetch_rsp_o),
      .refill_req_o        (refill_req_o),
      .tag_rd_en_o         (rd_en),
      .rd_set_o            (rd_set),
      .cmp_tag_o           (cmp_tag),
      .tag_wr_o            (tag_wr),
      .data_wr_mask_o      (data_wr_mask),
      .data_wr_set_o       (data_wr_set),
      .data_wr_line_o      (data_wr_line),
      .victim_advance_o    (victim_advance),
      .perf_o              (perf),
      .cache_is_bypassed_o (cache_is_bypassed_o),
      .cache_is_flushed_o  (cache_is_flushed_o),
      .flush_set_ack_o     (flush_set_ack_o)
   );

   icache_tag_store u_tags (
      .clk          (clk),
      .rst_n        (rst_n),
      .rd_en_i      (rd_en),
      .rd_set_i     (rd_set),
      .cmp_tag_i    (cmp_tag),
      .wr_i         (tag_wr),
      .hit_ways_o   (hit_ways),
      .valid_ways_o (valid_ways)
   );

   icache_data_store u_data (
      .clk        (clk),
      .rd_en_i    (rd_en),
      .rd_set_i   (rd_set),
      .wr_mask_i  (data_wr_mask),
      .wr_set_i   (data_wr_set),
      .wr_line_i  (data_wr_line),
      .rd_lines_o (rd_lines)
   );

   icache_victim_select u_victim (
      .clk          (clk),
      .rst_n        (rst_n),
      .advance_i    (victim_advance),
      .valid_ways_i (valid_ways),
      .victim_o     (victim)
   );

   icache_perf_counters u_stats (
      .clk          (clk),
      .rst_n        (rst_n),
      .clear_i      (stat_clear_i),
      .enable_i     (stat_enable_i),
      .event_i      (perf),
      .stat_trans_o (stat_trans_o),
      .stat_hit_o   (stat_hit_o),
      .stat_miss_o  (stat_miss_o),
      .stat_evict_o (stat_evict_o)
   );

endmodule

// ==== testbench/tb_checks.svh ====
// Compare tasks for lines, flags and counts
// Expected refill line for an address

`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

localparam icache_pkg::line_t LINE_XOR = 128'h5a5a_0f0f_c3c3_9669_a5a5_f0f0_3c3c_6996;

// Line address four times over, scrambled so that each word differs
function automatic icache_pkg::line_t line_for_addr(input icache_pkg::addr_t addr);
   icache_pkg::addr_t line_addr;
   line_addr = {addr[icache_pkg::ADDR_W-1:icache_pkg::OFFSET_W], {icache_pkg::OFFSET_W{1'b0}}};
   return {4{line_addr}} ^ LINE_XOR;
endfunction

task automatic check_line(input string what, input icache_pkg::line_t got,
                          input icache_pkg::line_t exp);
   if (got !== exp)
   begin
      err_cnt++;
      $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
   end
endtask

task automatic check_flag(input string what, input logic got, input logic exp);
   if (got !== exp)
   begin
      err_cnt++;
      $display("MISMATCH at %0t: %s got %b expected %b", $time, what, got, exp);
   end
endtask

task automatic check_count(input string what, input icache_pkg::stat_cnt_t got,
                           input icache_pkg::stat_cnt_t exp);
   if (got !== exp)
   begin
      err_cnt++;
      $display("MISMATCH at %0t: %s got %0d expected %0d", $time, what, got, exp);
   end
endtask

`endif

// ==== testbench/tb_pri_icache.sv ====
// Testbench for the private instruction cache
// Clock, reset, refill memory model, operation table and summary

`timescale 1ns/1ps

module tb_pri_icache;

   localparam int SET_LSB = icache_pkg::OFFSET_W;

   typedef enum logic [2:0] {OP_FETCH, OP_FLUSH_ALL, OP_FLUSH_SET, OP_BYPASS_ON, OP_BYPASS_OFF} op_t;

   typedef struct packed {
      op_t               op;
      icache_pkg::addr_t addr;
      logic              exp_hit;
   } row_t;

   logic                      clk;
   logic                      rst_n;
   logic                      fetch_req_i;
   icache_pkg::addr_t         fetch_addr_i;
   logic                      fetch_gnt_o;
   icache_pkg::fetch_rsp_t    fetch_rsp_o;
   icache_pkg::refill_req_t   refill_req_o;
   icache_pkg::refill_rsp_t   refill_rsp_i = '0;
   logic                      bypass_i;
   logic                      flush_i;
   logic                      flush_set_req_i;
   icache_pkg::addr_t         flush_set_addr_i;
   logic                      flush_set_ack_o;
   logic                      cache_is_bypassed_o;
   logic                      cache_is_flushed_o;
   logic                      stat_clear_i;
   logic                      stat_enable_i;
   icache_pkg::stat_cnt_t     stat_trans_o;
   icache_pkg::stat_cnt_t     stat_hit_o;
   icache_pkg::stat_cnt_t     stat_miss_o;
   icache_pkg::stat_cnt_t     stat_evict_o;

   row_t              rows[$];
   int                err_cnt = 0;
   int                pass_cnt = 0;
   int                fail_cnt = 0;
   int                cycle_cnt = 0;
   int                cycle_limit = 200;
   int                refill_cnt = 0;     // Requests accepted by the memory model
   integer            seed = 32'h0e2a_21ca;
   logic              mem_busy = 1'b0;
   int                gnt_delay;
   icache_pkg::addr_t mem_addr;
   int                exp_trans = 0;
   int                exp_hits = 0;
   int                exp_misses = 0;
   int                exp_evicts = 0;
   int                valid_lines [icache_pkg::NB_SETS];   // Lines held per set
   logic              in_bypass = 1'b0;

   `include "tb_checks.svh"

   pri_icache UUT (.*);

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   ///////////////////////////////
   // Refill memory model
   ///////////////////////////////
   always @(posedge clk)
   begin
      if (rst_n)
      begin
         refill_rsp_i.valid <= 1'b0;
         if (refill_rsp_i.gnt)
         begin
            refill_rsp_i.gnt   <= 1'b0;
            refill_rsp_i.valid <= 1'b1;   // Single beat right after the grant
            refill_rsp_i.data  <= line_for_addr(mem_addr);
            mem_busy = 1'b0;
         end
         else if (refill_req_o.req && !mem_busy)
         begin
            mem_busy  = 1'b1;
            mem_addr  = refill_req_o.addr;
            gnt_delay = $random(seed) & 3;
            refill_cnt++;
            if (gnt_delay == 0)
               refill_rsp_i.gnt <= 1'b1;
         end
         else if (mem_busy)
         begin
            gnt_delay--;
            if (gnt_delay == 0)
               refill_rsp_i.gnt <= 1'b1;
         end
      end
   end

   initial
   begin
      while (cycle_cnt < cycle_limit)
      begin
         @(posedge clk);
         cycle_cnt++;
      end
      $display("TIMEOUT: the DUT did not finish within %0d cycles", cycle_limit);
      $display("SOME TESTS FAILED");
      $finish;
   end

   task automatic add_row(input op_t op, input icache_pkg::addr_t addr, input logic hit);
      rows.push_back('{op: op, addr: addr, exp_hit: hit});
   endtask

   task automatic build_table();
      add_row(OP_FETCH,      32'h0000_0100, 1'b0);   // Cold miss, then hit
      add_row(OP_FETCH,      32'h0000_0100, 1'b1);
      add_row(OP_FETCH,      32'h0000_0230, 1'b0);
      add_row(OP_FETCH,      32'h0000_0234, 1'b1);   // Same line, other offset
      add_row(OP_FLUSH_ALL,  32'h0000_0000, 1'b0);
      add_row(OP_FETCH,      32'h0000_0100, 1'b0);
      add_row(OP_FETCH,      32'h0000_0230, 1'b0);
      add_row(OP_FLUSH_SET,  32'h0000_0100, 1'b0);
      add_row(OP_FETCH,      32'h0000_0100, 1'b0);
      add_row(OP_FETCH,      32'h0000_0230, 1'b1);   // Other set survives
      add_row(OP_BYPASS_ON,  32'h0000_0000, 1'b0);
      add_row(OP_FETCH,      32'h0000_0450, 1'b0);
      add_row(OP_FETCH,      32'h0000_0450, 1'b0);
      add_row(OP_FETCH,      32'h0000_0230, 1'b0);
      add_row(OP_BYPASS_OFF, 32'h0000_0000, 1'b0);
      add_row(OP_FETCH,      32'h0000_0230, 1'b0);
      for (int t = 1; t <= 5; t++)
         add_row(OP_FETCH, 32'h0000_0060 | (t << 8), 1'b0);   // Five tags in set 6
      add_row(OP_FETCH,      32'h0000_0230, 1'b1);
      add_row(OP_FETCH,      32'h0000_0100, 1'b0);
      add_row(OP_FETCH,      32'h0000_010c, 1'b1);
   endtask

   task automatic fetch_line(input icache_pkg::addr_t addr, output icache_pkg::line_t data,
                             output int refills);
      int start;
      start = refill_cnt;
      @(posedge clk);
      fetch_req_i  <= 1'b1;
      fetch_addr_i <= addr;
      @(negedge clk);
      while (!fetch_gnt_o)
         @(negedge clk);
      @(posedge clk);
      fetch_req_i <= 1'b0;
      @(negedge clk);
      while (!fetch_rsp_o.valid)
         @(negedge clk);
      data    = fetch_rsp_o.data;
      refills = refill_cnt - start;
   endtask

   task automatic flush_all_sets(output int cycles);
      @(posedge clk);
      flush_i <= 1'b1;
      @(posedge clk);
      flush_i <= 1'b0;
      cycles = 1;
      @(negedge clk);
      while (!cache_is_flushed_o)
      begin
         cycles++;
         @(negedge clk);
      end
   endtask

   task automatic set_bypass(input logic on);
      @(posedge clk);
      bypass_i <= on;
      @(posedge clk);
      @(negedge clk);
      check_flag("cache_is_bypassed_o", cache_is_bypassed_o, on);
   endtask

   task automatic check_counters(input int trans, input int hits, input int misses,
                                 input int evicts);
      check_count("stat_trans_o", stat_trans_o, trans);
      check_count("stat_hit_o", stat_hit_o, hits);
      check_count("stat_miss_o", stat_miss_o, misses);
      check_count("stat_evict_o", stat_evict_o, evicts);
   endtask

   task automatic close_test(input string name, input int errs_before);
      if (err_cnt == errs_before)
      begin
         pass_cnt++;
         $display("PASS  %s", name);
      end
      else
      begin
         fail_cnt++;
         $display("FAIL  %s", name);
      end
   endtask

   ///////////////////////////////
   // Main sequence
   ///////////////////////////////
   initial
   begin
      icache_pkg::line_t    got;
      icache_pkg::set_idx_t set_idx;
      int                   refills;
      int                   cycles;
      int                   errs_before;

      rst_n            = 1'b0;
      fetch_req_i      = 1'b0;
      fetch_addr_i     = '0;
      bypass_i         = 1'b0;
      flush_i          = 1'b0;
      flush_set_req_i  = 1'b0;
      flush_set_addr_i = '0;
      stat_clear_i     = 1'b0;
      stat_enable_i    = 1'b1;
      foreach (valid_lines[s])
         valid_lines[s] = 0;
      build_table();
      cycle_limit = 40 * rows.size() + 200;
      repeat (3) @(posedge clk);
      rst_n <= 1'b1;

      foreach (rows[i])
      begin
         errs_before = err_cnt;
         set_idx     = rows[i].addr[SET_LSB +: icache_pkg::SET_W];
         case (rows[i].op)
            OP_FETCH:
            begin
               fetch_line(rows[i].addr, got, refills);
               check_line("fetch data", got, line_for_addr(rows[i].addr));
               check_flag("hit", refills == 0, rows[i].exp_hit);
               check_count("refill requests", refills, rows[i].exp_hit ? 0 : 1);
               exp_trans++;
               if (!in_bypass && rows[i].exp_hit)
                  exp_hits++;
               else if (!in_bypass)
               begin
                  exp_misses++;
                  if (valid_lines[set_idx] == icache_pkg::NB_WAYS)
                     exp_evicts++;   // Full set, a valid line is replaced
                  else
                     valid_lines[set_idx]++;
               end
            end
            OP_FLUSH_ALL:
            begin
               flush_all_sets(cycles);
               check_count("flush cycles", cycles, icache_pkg::NB_SETS);
               foreach (valid_lines[s])
                  valid_lines[s] = 0;
            end
            OP_FLUSH_SET:
            begin
               @(posedge clk);
               flush_set_req_i  <= 1'b1;
               flush_set_addr_i <= rows[i].addr;
               @(posedge clk);
               flush_set_req_i <= 1'b0;
               @(negedge clk);
               check_flag("flush_set_ack_o", flush_set_ack_o, 1'b1);
               valid_lines[set_idx] = 0;
            end
            OP_BYPASS_ON:
            begin
               set_bypass(1'b1);
               in_bypass = 1'b1;
            end
            default:
            begin
               set_bypass(1'b0);   // Leaving bypass flushes everything
               in_bypass = 1'b0;
               foreach (valid_lines[s])
                  valid_lines[s] = 0;
            end
         endcase
         close_test($sformatf("row %0d %s addr %h", i, rows[i].op.name(), rows[i].addr),
                    errs_before);
      end

      // Counters update one cycle after their strobes
      errs_before = err_cnt;
      repeat (2) @(posedge clk);
      @(negedge clk);
      check_counters(exp_trans, exp_hits, exp_misses, exp_evicts);
      close_test("statistics counters", errs_before);

      errs_before = err_cnt;
      @(posedge clk);
      stat_enable_i <= 1'b0;
      fetch_line(32'h0000_0230, got, refills);
      check_line("fetch data", got, line_for_addr(32'h0000_0230));
      repeat (2) @(posedge clk);
      @(negedge clk);
      check_counters(exp_trans, exp_hits, exp_misses, exp_evicts);
      close_test("statistics hold while disabled", errs_before);

      errs_before = err_cnt;
      @(posedge clk);
      stat_clear_i <= 1'b1;
      @(posedge clk);
      stat_clear_i <= 1'b0;
      @(negedge clk);
      check_counters(0, 0, 0, 0);
      close_test("statistics clear", errs_before);

      $display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
      if (fail_cnt == 0)
         $display("ALL TESTS PASSED");
      else
         $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

// ==== all.f ====
+incdir+testbench
hdl/icache_pkg.sv
hdl/icache_tag_store.sv
hdl/icache_data_store.sv
hdl/icache_victim_select.sv
hdl/icache_ctrl_fsm.sv
hdl/icache_perf_counters.sv
hdl/pri_icache.sv
testbench/tb_pri_icache.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the instruction cache testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
   --top-module tb_pri_icache \
   -f all.f \
   --Mdir obj_dir \
   -o sim_pri_icache

./obj_dir/sim_pri_icache | tee sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
   echo "simulation reported failures, see sim.log"
   exit 1
fi

echo "simulation finished without failures"
